/* hw/mbu_macros.svh */
// MBU constants: unit addresses, power-on bank defaults and register file geometry
`ifndef MBU_MACROS_SVH
`define MBU_MACROS_SVH

////////////////////
// Unit addresses
////////////////////

// MBn shares one code on both units
`define MBU_RADDR_MBN   5'b11011
`define MBU_WADDR_MBN   5'b11011
`define MBU_ADDR_MBP    5'b11100   // MB0, read and write

// Two aliases for the context register
`define MBU_ADDR_CTX_A  5'b11110
`define MBU_ADDR_CTX_B  5'b11101

`define MBU_WAR_PREFIX  3'b001     // Compared against waddr[4:2]

////////////////////
// Power-on defaults
////////////////////

`define MBU_ROM_BANK    8'h80      // MB0 when booting from ROM
`define MBU_RAM_BANK    8'h00      // MB0 with front panel RAM switch, all other MBs

////////////////////
// Geometry
////////////////////

`define MBU_BANKS       8          // Registers per context
`define MBU_CTX_COUNT   256

`endif

/* hw/mbu_pkg.sv */
// MBU shared types: bank numbers, contexts, register indices and read sources
package mbu_pkg;

   ////////////////////
   // Data types
   ////////////////////

   // Bank number as driven on aext
   typedef logic [7:0] bank_t;

   typedef logic [7:0] ctx_t;      // One of 256 contexts

   typedef logic [2:0] mb_idx_t;   // MB0..MB7

   // Control unit read or write unit address
   typedef logic [4:0] unit_addr_t;

   ////////////////////
   // Read source select
   ////////////////////

   // What the unit puts on the internal bus next cycle
   typedef enum logic [1:0] {
      RD_NONE = 2'd0,   // Not addressed, bus released
      RD_MBN  = 2'd1,   // MB[ir]
      RD_MBP  = 2'd2,   // MB0
      RD_CTX  = 2'd3    // Context register
   } rd_src_e;

endpackage

/* hw/mbu_decode.sv */
// MBU address decoder: turns read and write unit addresses into read source and write strobes
`include "mbu_macros.svh"

module mbu_decode import mbu_pkg::*; (
   input  unit_addr_t raddr,    // Read unit
   input  unit_addr_t waddr,    // Write unit
   output rd_src_e    rd_src,   // Bus source for this cycle
   output logic       wr_mbn,   // Write ibus to MB[ir]
   output logic       wr_mbp,   // Write ibus to MB0
   output logic       wr_ctx,   // Write ibus to CTX
   output logic       war       // Any of the four AR write strobes
);

   ////////////////////
   // Read side
   ////////////////////

   // Read codes never overlap, so a plain case is enough
   always_comb begin
      case (raddr)
         `MBU_RADDR_MBN: rd_src = RD_MBN;
         `MBU_ADDR_MBP:  rd_src = RD_MBP;
         `MBU_ADDR_CTX_A,
         `MBU_ADDR_CTX_B: rd_src = RD_CTX;   // Both CTX aliases
         default:        rd_src = RD_NONE;  // Some other unit
      endcase
   end

   ////////////////////
   // Write side
   ////////////////////

   // One strobe at most per cycle
   assign wr_mbn = (waddr == `MBU_WADDR_MBN);
   assign wr_mbp = (waddr == `MBU_ADDR_MBP);
   assign wr_ctx = (waddr == `MBU_ADDR_CTX_A) ||
                   (waddr == `MBU_ADDR_CTX_B);

   // Flags alias of the original not decoded

   // AR writes sit in a block of four
   assign war = (waddr[4:2] == `MBU_WAR_PREFIX);

endmodule

/* hw/mbu_context.sv */
// MBU context and mode state: context register, unit enable and AR index select
module mbu_context import mbu_pkg::*; (
   input  logic  clk4,
   input  logic  rst,
   input  logic  wr_ctx,    // Load CTX from ibus
   input  logic  wr_mbn,    // First one brings the unit out of reset
   input  logic  ir_idx,    // Control unit asks for raddr index on war
   input  bank_t ibus_in,
   output ctx_t  ctx,
   output logic  enabled,   // Low: power-on defaults on bank reads
   output logic  idx_sel    // High: war uses raddr[1:0] as index
);

   ////////////////////
   // Context register
   ////////////////////

   // Selects which set of eight MBs is live
   always_ff @(posedge clk4) begin
      if (rst) begin
         ctx <= '0;
      end else if (wr_ctx) begin
         ctx <= ctx_t'(ibus_in);
      end
   end

   ////////////////////
   // Enable and index flags
   ////////////////////

   // Both are set-only flags, cleared by reset alone
   always_ff @(posedge clk4) begin
      if (rst) begin
         enabled <= 1'b0;          // Defaults until first MBn write
         idx_sel <= 1'b0;          // ir selects the MB on war
      end else begin
         if (wr_mbn) begin
            enabled <= 1'b1;       // Stays on until reset
         end
         if (ir_idx) begin
            idx_sel <= 1'b1;       // Pulse latched, as the index FF
         end
      end
   end

   // Enable and CTX load are independent, same edge is fine

endmodule

/* hw/mbu_bank_file.sv */
// MBU bank register file: eight bank registers per context, read mux, defaults and AR extension
`include "mbu_macros.svh"

module mbu_bank_file import mbu_pkg::*; (
   input  logic       clk4,
   input  logic       rst,
   input  rd_src_e    rd_src,      // From decoder, this cycle
   input  logic       wr_mbn,
   input  logic       wr_mbp,
   input  logic       war,
   input  logic       enabled,     // Low: serve power-on defaults
   input  logic       idx_sel,     // High: war index from raddr
   input  logic       fp_ram,      // Front panel RAM/ROM switch
   input  ctx_t       ctx,
   input  mb_idx_t    ir,          // Index from instruction register
   input  logic [1:0] raddr_low,   // raddr[1:0]
   input  bank_t      ibus_in,
   output bank_t      ibus_out,
   output logic       ibus_oe,
   output bank_t      aext         // Extended address bus
);

   localparam int MEM_DEPTH = `MBU_CTX_COUNT * `MBU_BANKS;   // 2048 entries
   localparam int MEM_AW    = $clog2(MEM_DEPTH);

   bank_t             mem [MEM_DEPTH];   // {ctx, index} addressed
   logic [MEM_AW-1:0] wr_addr;
   logic              wr_en;
   mb_idx_t           ar_idx;            // MB picked for aext
   bank_t             rd_val;            // Next ibus_out
   bank_t             ar_val;            // Next aext

   // Value a disabled unit returns for a bank read
   function automatic bank_t default_bank(mb_idx_t idx, logic ram);
      bank_t val;
      val = `MBU_RAM_BANK;                 // Every MB but MB0
      if (idx == '0 && !ram) begin
         val = `MBU_ROM_BANK;              // Boot from ROM bank
      end
      return val;
   endfunction

   // Bank read through the current context, defaults while disabled
   function automatic bank_t bank_read(mb_idx_t idx);
      bank_t val;
      val = enabled ? mem[{ctx, idx}] : default_bank(idx, fp_ram);
      return val;
   endfunction

   ////////////////////
   // Write port
   ////////////////////

   // Decoder keeps wr_mbn and wr_mbp exclusive
   assign wr_en   = wr_mbn || wr_mbp;
   assign wr_addr = wr_mbn ? {ctx, ir} : {ctx, mb_idx_t'(0)};   // MBP is MB0

   always_ff @(posedge clk4) begin
      if (wr_en) begin
         mem[wr_addr] <= ibus_in;   // Same edge read sees old value
      end
   end

   ////////////////////
   // Read mux
   ////////////////////

   always_comb begin
      case (rd_src)
         RD_MBN:  rd_val = bank_read(ir);
         RD_MBP:  rd_val = bank_read(mb_idx_t'(0));
         RD_CTX:  rd_val = bank_t'(ctx);    // No default on CTX
         default: rd_val = '0;              // Bus released anyway
      endcase
   end

   // Index source flips once ir_idx has been seen
   assign ar_idx = idx_sel ? {1'b0, raddr_low} : ir;
   assign ar_val = bank_read(ar_idx);

   ////////////////////
   // Output registers
   ////////////////////

   // Bus data, qualified by ibus_oe
   always_ff @(posedge clk4) begin
      ibus_out <= rd_val;
   end

   always_ff @(posedge clk4) begin
      if (rst) begin
         ibus_oe <= 1'b0;
         aext    <= '0;
      end else begin
         ibus_oe <= (rd_src != RD_NONE);   // One cycle after the address
         if (war) begin
            aext <= ar_val;                 // Held until next war
         end
      end
   end

endmodule

/* hw/mbu.sv */
// Memory bank unit top: decoder, context state and bank register file
module mbu import mbu_pkg::*; (
   input  logic       clk4,
   input  logic       rst,
   input  unit_addr_t raddr,      // Control unit read address
   input  unit_addr_t waddr,      // Control unit write address
   input  bank_t      ibus_in,
   input  mb_idx_t    ir,
   input  logic       ir_idx,     // One cycle pulse
   input  logic       fp_ram,     // Level from front panel
   output bank_t      ibus_out,
   output logic       ibus_oe,
   output logic       war,        // To the address register
   output bank_t      aext
);

   ////////////////////
   // Internal wires
   ////////////////////

   rd_src_e rd_src;
   logic    wr_mbn;
   logic    wr_mbp;
   logic    wr_ctx;
   ctx_t    ctx;
   logic    enabled;
   logic    idx_sel;

   // Address decode, all combinational
   mbu_decode u_decode (
      .raddr  (raddr),
      .waddr  (waddr),
      .rd_src (rd_src),
      .wr_mbn (wr_mbn),
      .wr_mbp (wr_mbp),
      .wr_ctx (wr_ctx),
      .war    (war)
   );

   // CTX, enable and index flag
   mbu_context u_context (
      .clk4    (clk4),
      .rst     (rst),
      .wr_ctx  (wr_ctx),
      .wr_mbn  (wr_mbn),
      .ir_idx  (ir_idx),
      .ibus_in (ibus_in),
      .ctx     (ctx),
      .enabled (enabled),
      .idx_sel (idx_sel)
   );

   mbu_bank_file u_bank_file (
      .clk4      (clk4),
      .rst       (rst),
      .rd_src    (rd_src),
      .wr_mbn    (wr_mbn),
      .wr_mbp    (wr_mbp),
      .war       (war),
      .enabled   (enabled),
      .idx_sel   (idx_sel),
      .fp_ram    (fp_ram),
      .ctx       (ctx),
      .ir        (ir),
      .raddr_low (raddr[1:0]),   // AR index when idx_sel set
      .ibus_in   (ibus_in),
      .ibus_out  (ibus_out),
      .ibus_oe   (ibus_oe),
      .aext      (aext)
   );

endmodule

/* verification/mbu_assert.sv */
// MBU output assertions: bus enable timing and aext hold between AR writes
`include "mbu_macros.svh"

module mbu_assert import mbu_pkg::*; (
   input logic       clk4,
   input logic       rst,
   input unit_addr_t raddr,
   input logic       ibus_oe,
   input logic       war,
   input bank_t      aext
);
   timeunit 1ns;
   timeprecision 1ps;

   logic rd_hit;       // raddr names this unit
   logic past_valid;   // $past has history

   assign rd_hit = (raddr == `MBU_RADDR_MBN) || (raddr == `MBU_ADDR_MBP) ||
                   (raddr == `MBU_ADDR_CTX_A) || (raddr == `MBU_ADDR_CTX_B);

   initial past_valid = 1'b0;

   always @(posedge clk4) begin
      past_valid <= 1'b1;
   end

   ////////////////////
   // Properties
   ////////////////////

   a_oe_in_reset: assert property (@(posedge clk4) rst |=> !ibus_oe)
      else $error("ibus_oe high after a reset cycle");

   // Bus enable only follows a read address of the unit
   a_oe_after_read: assert property (@(posedge clk4) disable iff (rst)
      (past_valid && ibus_oe) |-> $past(rd_hit))
      else $error("ibus_oe high without a read address one cycle earlier");

   a_read_sets_oe: assert property (@(posedge clk4) disable iff (rst) rd_hit |=> ibus_oe)
      else $error("ibus_oe low after a read address");

   // aext moves only at the edge that closes a war cycle
   a_aext_hold: assert property (@(posedge clk4)
      (past_valid && !$past(war) && !$past(rst)) |-> $stable(aext))
      else $error("aext changed without a war cycle");

endmodule

bind mbu mbu_assert u_assert (
   .clk4    (clk4),
   .rst     (rst),
   .raddr   (raddr),
   .ibus_oe (ibus_oe),
   .war     (war),
   .aext    (aext)
);

/* verification/mbu_tb.sv */
// MBU testbench driving seeded random unit traffic against a cycle model
`include "mbu_macros.svh"

module mbu_tb import mbu_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   localparam unit_addr_t IDLE_ADDR = 5'b00000;   // Neither an MBU unit nor war

   logic       clk4;
   logic       rst;
   unit_addr_t raddr;
   unit_addr_t waddr;
   bank_t      ibus_in;
   mb_idx_t    ir;
   logic       ir_idx;
   logic       fp_ram;
   bank_t      ibus_out;
   logic       ibus_oe;
   logic       war;
   bank_t      aext;

   // Reference model for contexts 0..3 only
   bank_t m_bank    [4][`MBU_BANKS];
   bit    m_written [4][`MBU_BANKS];
   ctx_t  m_ctx;
   bit    m_enabled;
   bit    m_idx_sel;

   // Expected outputs one cycle behind the inputs
   logic  exp_oe;
   bank_t exp_data;
   bit    data_known;   // Clear for unwritten entries
   bank_t exp_aext;
   bit    aext_known;

   int mismatch_count;
   int other_count;

   mbu DUT (
      .clk4     (clk4),
      .rst      (rst),
      .raddr    (raddr),
      .waddr    (waddr),
      .ibus_in  (ibus_in),
      .ir       (ir),
      .ir_idx   (ir_idx),
      .fp_ram   (fp_ram),
      .ibus_out (ibus_out),
      .ibus_oe  (ibus_oe),
      .war      (war),
      .aext     (aext)
   );

   initial begin
      clk4 = 1'b0;
      forever #10 clk4 = ~clk4;   // 20 ns period
   end

   ////////////////////
   // Compare tasks
   ////////////////////

   task automatic check_bank(input string name, input bank_t got, input bank_t exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got 8'h%02h, expected 8'h%02h",
                  $time, name, got, exp);
         mismatch_count++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
         mismatch_count++;
      end
   endtask

   ////////////////////
   // Reference model
   ////////////////////

   function automatic rd_src_e decode_read(input unit_addr_t a);
      rd_src_e src;
      src = RD_NONE;
      if (a == `MBU_RADDR_MBN) begin
         src = RD_MBN;
      end else if (a == `MBU_ADDR_MBP) begin
         src = RD_MBP;
      end else if (a == `MBU_ADDR_CTX_A || a == `MBU_ADDR_CTX_B) begin
         src = RD_CTX;   // Either alias
      end
      return src;
   endfunction

   function automatic bit is_ctx(input unit_addr_t a);
      return (a == `MBU_ADDR_CTX_A) || (a == `MBU_ADDR_CTX_B);
   endfunction

   // Bank as seen now and whether its value is known
   function automatic bit model_bank(input mb_idx_t idx, output bank_t val);
      if (!m_enabled) begin
         val = (idx == 3'd0 && !fp_ram) ? `MBU_ROM_BANK : `MBU_RAM_BANK;
         return 1'b1;
      end
      val = m_bank[m_ctx[1:0]][idx];
      return m_written[m_ctx[1:0]][idx];
   endfunction

   // One clock edge of the unit with reads from the state before it
   task automatic model_step(input unit_addr_t ra, input unit_addr_t wa,
                             input bank_t din, input mb_idx_t ri, input logic pulse);
      rd_src_e src;
      mb_idx_t ar;
      src        = decode_read(ra);
      exp_oe     = (src != RD_NONE);
      data_known = 1'b1;
      case (src)
         RD_MBN:  data_known = model_bank(ri, exp_data);
         RD_MBP:  data_known = model_bank(3'd0, exp_data);
         RD_CTX:  exp_data = bank_t'(m_ctx);
         default: data_known = 1'b0;     // Bus released
      endcase
      if (wa[4:2] == `MBU_WAR_PREFIX) begin
         ar         = m_idx_sel ? {1'b0, ra[1:0]} : ri;
         aext_known = model_bank(ar, exp_aext);
      end
      if (wa == `MBU_WADDR_MBN) begin
         m_bank[m_ctx[1:0]][ri]    = din;
         m_written[m_ctx[1:0]][ri] = 1'b1;
         m_enabled                 = 1'b1;   // First MBn write
      end
      if (wa == `MBU_ADDR_MBP) begin
         m_bank[m_ctx[1:0]][0]    = din;
         m_written[m_ctx[1:0]][0] = 1'b1;
      end
      if (is_ctx(wa)) begin
         m_ctx = ctx_t'(din);
      end
      if (pulse) begin
         m_idx_sel = 1'b1;
      end
   endtask

   ////////////////////
   // Stimulus
   ////////////////////

   function automatic unit_addr_t pick_raddr();
      int sel;
      sel = $urandom_range(9, 0);
      case (sel)
         0, 1, 2: return `MBU_RADDR_MBN;
         3, 4:    return `MBU_ADDR_MBP;
         5:       return `MBU_ADDR_CTX_A;
         6:       return `MBU_ADDR_CTX_B;
         default: return unit_addr_t'($urandom);   // Mostly other units
      endcase
   endfunction

   function automatic unit_addr_t pick_waddr(input bit allow_mbn);
      int         sel;
      unit_addr_t a;
      sel = $urandom_range(9, 0);
      case (sel)
         0, 1:    a = allow_mbn ? `MBU_WADDR_MBN : `MBU_ADDR_MBP;
         2, 3:    a = `MBU_ADDR_MBP;
         4:       a = ($urandom_range(1, 0) == 0) ? `MBU_ADDR_CTX_A : `MBU_ADDR_CTX_B;
         5, 6:    a = {`MBU_WAR_PREFIX, 2'($urandom_range(3, 0))};   // AR0..AR3
         default: a = unit_addr_t'($urandom);
      endcase
      if (!allow_mbn && a == `MBU_WADDR_MBN) begin
         a = IDLE_ADDR;   // Keep the unit disabled
      end
      return a;
   endfunction

   // Drive one cycle, check last cycle's results, then advance the model
   task automatic run_cycle(input bit allow_mbn, input bit allow_idx);
      unit_addr_t ra;
      unit_addr_t wa;
      bank_t      din;
      mb_idx_t    ri;
      logic       pulse;
      ra  = pick_raddr();
      wa  = pick_waddr(allow_mbn);
      din = bank_t'($urandom);
      if (is_ctx(wa)) begin
         din = bank_t'($urandom_range(3, 0));   // Four contexts only
      end
      ri    = mb_idx_t'($urandom);
      pulse = allow_idx && ($urandom_range(15, 0) == 0);
      @(posedge clk4);
      raddr   <= ra;
      waddr   <= wa;
      ibus_in <= din;
      ir      <= ri;
      ir_idx  <= pulse;
      @(negedge clk4);
      check_bit("war", war, wa[4:2] == `MBU_WAR_PREFIX);   // Same cycle
      check_bit("ibus_oe", ibus_oe, exp_oe);
      if (exp_oe && data_known) begin
         check_bank("ibus_out", ibus_out, exp_data);
      end
      if (aext_known) begin
         check_bank("aext", aext, exp_aext);
      end
      model_step(ra, wa, din, ri, pulse);
   endtask

   task automatic run_phase(input int cycles, input bit allow_mbn, input bit allow_idx);
      for (int i = 0; i < cycles; i++) begin
         run_cycle(allow_mbn, allow_idx);
      end
   endtask

   // Outputs must settle to reset values within a few cycles
   task automatic wait_reset_clear();
      bit done;
      done = 1'b0;
      for (int cyc = 0; cyc < 8 && !done; cyc++) begin
         @(negedge clk4);
         done = (ibus_oe === 1'b0) && (aext === '0);
      end
      if (!done) begin
         $display("Error at %0t: outputs did not reach reset values after rst", $time);
         other_count++;
      end
   endtask

   // Memory and model banks keep their contents across reset
   task automatic apply_reset(input logic ram);
      @(posedge clk4);
      rst    <= 1'b1;
      raddr  <= IDLE_ADDR;
      waddr  <= IDLE_ADDR;
      ir_idx <= 1'b0;
      fp_ram <= ram;
      for (int cyc = 0; cyc < 16; cyc++) begin
         @(posedge clk4);
      end
      rst        <= 1'b0;
      m_ctx      = '0;
      m_enabled  = 1'b0;
      m_idx_sel  = 1'b0;
      exp_oe     = 1'b0;
      data_known = 1'b0;
      exp_aext   = '0;
      aext_known = 1'b1;
      wait_reset_clear();
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      rst            = 1'b1;
      raddr          = IDLE_ADDR;
      waddr          = IDLE_ADDR;
      ibus_in        = '0;
      ir             = '0;
      ir_idx         = 1'b0;
      fp_ram         = 1'b0;
      mismatch_count = 0;
      other_count    = 0;
      $timeformat(-9, 0, " ns", 0);
      void'($urandom(32'h1ed));
      apply_reset(1'b0);        // ROM boot
      run_phase(40, 1'b0, 1'b0);   // Defaults only
      run_phase(300, 1'b1, 1'b0);
      run_phase(200, 1'b1, 1'b1);  // AR index from raddr after a pulse
      apply_reset(1'b1);        // RAM boot with idx_sel cleared
      run_phase(40, 1'b0, 1'b0);
      run_phase(200, 1'b1, 1'b1);
      $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
      if (mismatch_count == 0 && other_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

/* project.f */
+incdir+hw
hw/mbu_pkg.sv
hw/mbu_decode.sv
hw/mbu_context.sv
hw/mbu_bank_file.sv
hw/mbu.sv
verification/mbu_assert.sv
verification/mbu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the MBU testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module mbu_tb \
   -f project.f -Mdir "$OBJ" -o mbu_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/mbu_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

# Assertion stops end the run with a nonzero status
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
   echo "FAIL"
   exit 1
fi

echo "PASS"
exit 0
